//--- Makefile
# Verilator build and run of the SoC bus testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_top
FLIST     ?= flist.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing -j 0

# Sources come from the file list, include directories left out
SOURCES := $(filter-out +%,$(shell cat $(FLIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# Exit status of the binary is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- flist.f
logic/soc_bus_pkg.sv
logic/soc_csr_pkg.sv
logic/sys_bus_if.sv
logic/csr_bus_if.sv
logic/bus_decode.sv
logic/bram_store.sv
logic/csr_bridge.sv
logic/sysctl_gpio.sv
logic/soc_top.sv
testbench/tb_clkgen.sv
testbench/tb_soc_top.sv

//--- logic/bram_store.sv
//------------------------------------------------------------
// Block RAM target, 32-bit words with byte-lane writes
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bram_store (
	input wire       sys_clk,
	input wire       arst_n_i,
	sys_bus_if.slave bus
);

	soc_bus_pkg::data_t     mem [soc_bus_pkg::BRAM_WORDS];
	soc_bus_pkg::bram_idx_t idx;
	logic                   access;

	// Word index, upper bits alias inside the region
	assign idx = bus.adr[soc_bus_pkg::BRAM_IDX_LSB +: soc_bus_pkg::BRAM_IDX_W];

	// One access per strobe, the ack cycle is not an access
	assign access = bus.stb && !bus.ack;

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i)
			bus.ack <= 1'b0;
		else
			bus.ack <= access;
	end

	//------------------------------------------------------------
	// Storage
	//------------------------------------------------------------
	// Read-first, a write returns the old word
	always_ff @(posedge sys_clk) begin
		if (access) begin
			bus.dat_r <= mem[idx];
			if (bus.we) begin
				for (int i = 0; i < soc_bus_pkg::SEL_W; i++) begin
					// Only enabled lanes change
					if (bus.sel[i])
						mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/bus_decode.sv
//------------------------------------------------------------
// Host port region decoder with default responder
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bus_decode (
	input  wire                     sys_clk,
	input  wire                     arst_n_i,
	input  wire soc_bus_pkg::adr_t  host_adr_i,
	input  wire soc_bus_pkg::data_t host_dat_i,
	input  wire soc_bus_pkg::sel_t  host_sel_i,
	input  wire                     host_we_i,
	input  wire                     host_stb_i,
	output soc_bus_pkg::data_t      host_dat_o,
	output logic                    host_ack_o,
	sys_bus_if.master               bram_bus,
	sys_bus_if.master               csr_bus
);

	typedef enum logic [1:0] {IDLE, WAIT_TARGET, RESPOND} state_t;

	state_t               state;
	soc_bus_pkg::region_t region_q;
	soc_bus_pkg::region_t region_in;
	logic                 tgt_ack;
	soc_bus_pkg::data_t   tgt_dat;

	// Top address bits pick the region
	assign region_in = host_adr_i[soc_bus_pkg::REGION_LSB +: soc_bus_pkg::REGION_W];

	// Host holds the request stable, so only the strobes are steered
	assign bram_bus.adr   = host_adr_i;
	assign bram_bus.dat_w = host_dat_i;
	assign bram_bus.sel   = host_sel_i;
	assign bram_bus.we    = host_we_i;
	assign csr_bus.adr    = host_adr_i;
	assign csr_bus.dat_w  = host_dat_i;
	assign csr_bus.sel    = host_sel_i;
	assign csr_bus.we     = host_we_i;

	//------------------------------------------------------------
	// Response select
	//------------------------------------------------------------
	// Unpopulated regions answer right away
	always_comb begin
		case (region_q)
			soc_bus_pkg::REGION_BRAM: begin
				tgt_ack = bram_bus.ack;
				tgt_dat = bram_bus.dat_r;
			end
			soc_bus_pkg::REGION_CSR: begin
				tgt_ack = csr_bus.ack;
				tgt_dat = csr_bus.dat_r;
			end
			default: begin
				tgt_ack = 1'b1;
				tgt_dat = soc_bus_pkg::DEFAULT_DATA;
			end
		endcase
	end

	//------------------------------------------------------------
	// Transaction FSM
	//------------------------------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state        <= IDLE;
			region_q     <= '0;
			bram_bus.stb <= 1'b0;
			csr_bus.stb  <= 1'b0;
			host_ack_o   <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					// Latch the region and strobe the matching target
					if (host_stb_i) begin
						state        <= WAIT_TARGET;
						region_q     <= region_in;
						bram_bus.stb <= (region_in == soc_bus_pkg::REGION_BRAM);
						csr_bus.stb  <= (region_in == soc_bus_pkg::REGION_CSR);
					end
				end
				WAIT_TARGET: begin
					if (tgt_ack) begin
						state        <= RESPOND;
						bram_bus.stb <= 1'b0;
						csr_bus.stb  <= 1'b0;
						host_ack_o   <= 1'b1;
					end
				end
				RESPOND: begin
					// Ack is a single pulse, then wait for the host to let go
					host_ack_o <= 1'b0;
					if (!host_stb_i)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Read data captured along with the ack
	always_ff @(posedge sys_clk) begin
		if (state == WAIT_TARGET && tgt_ack)
			host_dat_o <= tgt_dat;
	end

endmodule

`default_nettype wire

//--- logic/csr_bridge.sv
//------------------------------------------------------------
// Bus to CSR bridge, one CSR access per bus access
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module csr_bridge (
	input wire        sys_clk,
	input wire        arst_n_i,
	sys_bus_if.slave  bus,
	csr_bus_if.bridge csr
);

	typedef enum logic [1:0] {IDLE, ACCESS, RESPOND, WAIT_DROP} state_t;

	state_t state;

	// Slave read data is registered and lands in the ack cycle
	assign bus.dat_r = csr.csr_dr;

	//------------------------------------------------------------
	// Sequencer
	//------------------------------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state      <= IDLE;
			csr.csr_we <= 1'b0;
			bus.ack    <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					// Address goes out now, write strobe with it
					if (bus.stb) begin
						state      <= ACCESS;
						csr.csr_we <= bus.we;
					end
				end
				ACCESS: begin
					// Slave sampled the address, its data is next
					state      <= RESPOND;
					csr.csr_we <= 1'b0;
					bus.ack    <= 1'b1;
				end
				RESPOND: begin
					state   <= WAIT_DROP;
					bus.ack <= 1'b0;
				end
				WAIT_DROP: begin
					// Strobe may linger one cycle past the ack
					if (!bus.stb)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Address and write data, held until the next access
	always_ff @(posedge sys_clk) begin
		if (state == IDLE && bus.stb) begin
			csr.csr_a  <= bus.adr[soc_csr_pkg::CSR_ADR_LSB +: soc_csr_pkg::CSR_ADR_W];
			csr.csr_dw <= bus.dat_w;
		end
	end

endmodule

`default_nettype wire

//--- logic/csr_bus_if.sv
//------------------------------------------------------------
// CSR bus, bridge and slave views
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface csr_bus_if;

	// Bank in the upper bits, register in the lower
	soc_csr_pkg::csr_adr_t csr_a;
	// Single-cycle write strobe
	logic                  csr_we;
	soc_bus_pkg::data_t    csr_dw;
	// Registered in the slave
	soc_bus_pkg::data_t    csr_dr;

	modport bridge (output csr_a, csr_we, csr_dw, input csr_dr);
	modport slave (input csr_a, csr_we, csr_dw, output csr_dr);

endinterface

`default_nettype wire

//--- logic/soc_bus_pkg.sv
//------------------------------------------------------------
// Bus widths, memory map regions and BRAM geometry
//------------------------------------------------------------
`default_nettype none

package soc_bus_pkg;

	// Bus widths
	localparam int ADR_W    = 32;
	localparam int DATA_W   = 32;
	localparam int SEL_W    = 4;
	localparam int REGION_W = 3;

	typedef logic [ADR_W-1:0]    adr_t;
	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [SEL_W-1:0]    sel_t;
	typedef logic [REGION_W-1:0] region_t;

	// Region number sits in the top address bits
	localparam int REGION_LSB = ADR_W - REGION_W;

	// Populated regions
	localparam region_t REGION_BRAM = 3'd1; // 0x20000000
	localparam region_t REGION_CSR  = 3'd4; // 0x80000000

	// Answer for every region without a target
	localparam data_t DEFAULT_DATA = 32'habadface;

	// BRAM geometry, word index from address bits 11:2
	localparam int BRAM_WORDS   = 1024;
	localparam int BRAM_IDX_W   = 10;
	localparam int BRAM_IDX_LSB = 2;

	typedef logic [BRAM_IDX_W-1:0] bram_idx_t;

endpackage

`default_nettype wire

//--- logic/soc_csr_pkg.sv
//------------------------------------------------------------
// CSR address layout, GPIO widths, system controller map
//------------------------------------------------------------
`default_nettype none

package soc_csr_pkg;

	// CSR address is bus byte address bits 15:2
	localparam int CSR_ADR_W   = 14;
	localparam int CSR_BANK_W  = 4;
	localparam int CSR_REG_W   = 10;
	localparam int CSR_ADR_LSB = 2;

	typedef logic [CSR_ADR_W-1:0]  csr_adr_t;
	typedef logic [CSR_BANK_W-1:0] csr_bank_t;
	typedef logic [CSR_REG_W-1:0]  csr_reg_t;

	// System controller bank and registers
	localparam csr_bank_t SYSCTL_BANK  = 4'd1;
	localparam csr_reg_t  REG_GPIO_IN  = 10'd0;
	localparam csr_reg_t  REG_GPIO_OUT = 10'd1;
	localparam csr_reg_t  REG_IRQ_PEND = 10'd2;
	localparam csr_reg_t  REG_IRQ_MASK = 10'd3;
	localparam csr_reg_t  REG_SYS_ID   = 10'd4;

	// Board ID, "X401" in ASCII
	localparam soc_bus_pkg::data_t SYSTEM_ID = 32'h58343031;

	// GPIO widths
	localparam int GPIO_IN_W  = 13;
	localparam int GPIO_OUT_W = 14;

	typedef logic [GPIO_IN_W-1:0]  gpio_in_t;
	typedef logic [GPIO_OUT_W-1:0] gpio_out_t;

endpackage

`default_nettype wire

//--- logic/soc_top.sv
//------------------------------------------------------------
// SoC bus top: decoder, BRAM, CSR bridge, system controller
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module soc_top (
	input  wire                        sys_clk,
	input  wire                        arst_n_i,
	// Host port
	input  wire soc_bus_pkg::adr_t     wb_adr_i,
	input  wire soc_bus_pkg::data_t    wb_dat_i,
	input  wire soc_bus_pkg::sel_t     wb_sel_i,
	input  wire                        wb_we_i,
	input  wire                        wb_stb_i,
	output soc_bus_pkg::data_t         wb_dat_o,
	output logic                       wb_ack_o,
	// GPIO
	input  wire soc_csr_pkg::gpio_in_t gpio_in_i,
	output soc_csr_pkg::gpio_out_t     gpio_out_o,
	output logic                       irq_o
);

	// Decoder to targets
	sys_bus_if bram_bus ();
	sys_bus_if csr_bus ();

	// Bridge to the system controller
	csr_bus_if csr ();

	//------------------------------------------------------------
	// Region decode
	//------------------------------------------------------------
	bus_decode u_decode (
		.sys_clk    (sys_clk),
		.arst_n_i   (arst_n_i),
		.host_adr_i (wb_adr_i),
		.host_dat_i (wb_dat_i),
		.host_sel_i (wb_sel_i),
		.host_we_i  (wb_we_i),
		.host_stb_i (wb_stb_i),
		.host_dat_o (wb_dat_o),
		.host_ack_o (wb_ack_o),
		.bram_bus   (bram_bus.master),
		.csr_bus    (csr_bus.master)
	);

	//------------------------------------------------------------
	// Targets
	//------------------------------------------------------------
	// 0x20000000
	bram_store u_bram (
		.sys_clk  (sys_clk),
		.arst_n_i (arst_n_i),
		.bus      (bram_bus.slave)
	);

	// 0x80000000
	csr_bridge u_csr_bridge (
		.sys_clk  (sys_clk),
		.arst_n_i (arst_n_i),
		.bus      (csr_bus.slave),
		.csr      (csr.bridge)
	);

	// CSR bank 1
	sysctl_gpio u_sysctl (
		.sys_clk    (sys_clk),
		.arst_n_i   (arst_n_i),
		.csr        (csr.slave),
		.gpio_in_i  (gpio_in_i),
		.gpio_out_o (gpio_out_o),
		.irq_o      (irq_o)
	);

endmodule

`default_nettype wire

//--- logic/sys_bus_if.sv
//------------------------------------------------------------
// Internal Wishbone-style bus, master and slave views
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface sys_bus_if;

	// Request, driven by the decode stage
	soc_bus_pkg::adr_t  adr;
	soc_bus_pkg::data_t dat_w;
	soc_bus_pkg::sel_t  sel;
	logic               we;
	// Held until ack
	logic               stb;

	// Response, driven by the target
	soc_bus_pkg::data_t dat_r;
	// One-cycle pulse
	logic               ack;

	modport master (output adr, dat_w, sel, we, stb, input dat_r, ack);
	modport slave (input adr, dat_w, sel, we, stb, output dat_r, ack);

endinterface

`default_nettype wire

//--- logic/sysctl_gpio.sv
//------------------------------------------------------------
// System controller: GPIO, input-change IRQ, system ID
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sysctl_gpio (
	input  wire                        sys_clk,
	input  wire                        arst_n_i,
	csr_bus_if.slave                   csr,
	input  wire soc_csr_pkg::gpio_in_t gpio_in_i,
	output soc_csr_pkg::gpio_out_t     gpio_out_o,
	output logic                       irq_o
);

	soc_csr_pkg::gpio_in_t  sync_meta;
	soc_csr_pkg::gpio_in_t  sync_q;
	soc_csr_pkg::gpio_in_t  sync_prev;
	soc_csr_pkg::gpio_in_t  irq_pend;
	soc_csr_pkg::gpio_in_t  irq_mask;
	soc_csr_pkg::gpio_in_t  pend_clr;
	soc_csr_pkg::csr_bank_t bank;
	soc_csr_pkg::csr_reg_t  reg_sel;
	logic                   bank_hit;

	// Split the CSR address
	assign bank     = csr.csr_a[soc_csr_pkg::CSR_ADR_W-1 -: soc_csr_pkg::CSR_BANK_W];
	assign reg_sel  = csr.csr_a[soc_csr_pkg::CSR_REG_W-1:0];
	assign bank_hit = (bank == soc_csr_pkg::SYSCTL_BANK);

	// Write 1s to clear pending bits
	assign pend_clr = (csr.csr_we && bank_hit && reg_sel == soc_csr_pkg::REG_IRQ_PEND)
		? csr.csr_dw[soc_csr_pkg::GPIO_IN_W-1:0] : '0;

	//------------------------------------------------------------
	// Input synchronizer
	//------------------------------------------------------------
	// Two flops, then one more for change detect
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync_meta <= '0;
			sync_q    <= '0;
			sync_prev <= '0;
		end else begin
			sync_meta <= gpio_in_i;
			sync_q    <= sync_meta;
			sync_prev <= sync_q;
		end
	end

	//------------------------------------------------------------
	// Control registers
	//------------------------------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			gpio_out_o <= '0;
			irq_mask   <= '0;
			irq_pend   <= '0;
			irq_o      <= 1'b0;
		end else begin
			// New changes win over a clear in the same cycle
			irq_pend <= (irq_pend & ~pend_clr) | (sync_q ^ sync_prev);
			irq_o    <= |(irq_pend & irq_mask);
			if (csr.csr_we && bank_hit) begin
				case (reg_sel)
					soc_csr_pkg::REG_GPIO_OUT:
						gpio_out_o <= csr.csr_dw[soc_csr_pkg::GPIO_OUT_W-1:0];
					soc_csr_pkg::REG_IRQ_MASK:
						irq_mask <= csr.csr_dw[soc_csr_pkg::GPIO_IN_W-1:0];
					default: begin
					end
				endcase
			end
		end
	end

	// Read data, 0 for other banks and holes in the map
	always_ff @(posedge sys_clk) begin
		csr.csr_dr <= '0;
		if (bank_hit) begin
			case (reg_sel)
				soc_csr_pkg::REG_GPIO_IN:  csr.csr_dr <= soc_bus_pkg::data_t'(sync_q);
				soc_csr_pkg::REG_GPIO_OUT: csr.csr_dr <= soc_bus_pkg::data_t'(gpio_out_o);
				soc_csr_pkg::REG_IRQ_PEND: csr.csr_dr <= soc_bus_pkg::data_t'(irq_pend);
				soc_csr_pkg::REG_IRQ_MASK: csr.csr_dr <= soc_bus_pkg::data_t'(irq_mask);
				soc_csr_pkg::REG_SYS_ID:   csr.csr_dr <= soc_csr_pkg::SYSTEM_ID;
				default:                   csr.csr_dr <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_clkgen.sv
//------------------------------------------------------------
// Testbench clock, 8 ns period, and power-on reset
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
	output logic sys_clk,
	output logic arst_n_o
);

	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 4;

	// Reset released just after an edge, like all stimulus
	initial begin
		sys_clk  = 1'b0;
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#1;
		arst_n_o = 1'b1;
	end

	always #HALF_PERIOD sys_clk = ~sys_clk;

endmodule

`default_nettype wire

//--- testbench/tb_soc_top.sv
//------------------------------------------------------------
// SoC bus testbench: random accesses, reference model, checks
//------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_soc_top;

	localparam logic [31:0] SEED       = 32'h1de37d23;
	// About 400 accesses of at most 8 cycles, plus GPIO settle time and margin
	localparam int          MAX_CYCLES = 40000;
	// Slowest target answers in 4 cycles
	localparam int          ACK_LIMIT  = 16;

	logic                    sys_clk;
	logic                    arst_n;
	soc_bus_pkg::adr_t       wb_adr_i;
	soc_bus_pkg::data_t      wb_dat_i;
	soc_bus_pkg::sel_t       wb_sel_i;
	logic                    wb_we_i;
	logic                    wb_stb_i;
	soc_bus_pkg::data_t      wb_dat_o;
	logic                    wb_ack_o;
	soc_csr_pkg::gpio_in_t   gpio_in_i;
	soc_csr_pkg::gpio_out_t  gpio_out_o;
	logic                    irq_o;

	// Reference model state
	soc_bus_pkg::data_t      bram_model [soc_bus_pkg::BRAM_WORDS];
	bit                      bram_written [soc_bus_pkg::BRAM_WORDS];
	soc_bus_pkg::bram_idx_t  written_q [$];
	soc_csr_pkg::gpio_out_t  gpio_out_model;
	soc_csr_pkg::gpio_in_t   gpio_in_model;
	soc_csr_pkg::gpio_in_t   mask_model;
	soc_csr_pkg::gpio_in_t   pend_model;

	logic [31:0]             rand_state = SEED;
	int                      cycle_cnt  = 0;

	tb_clkgen u_clkgen (
		.sys_clk  (sys_clk),
		.arst_n_o (arst_n)
	);

	soc_top dut (
		.sys_clk    (sys_clk),
		.arst_n_i   (arst_n),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_sel_i   (wb_sel_i),
		.wb_we_i    (wb_we_i),
		.wb_stb_i   (wb_stb_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.gpio_in_i  (gpio_in_i),
		.gpio_out_o (gpio_out_o),
		.irq_o      (irq_o)
	);

	//------------------------------------------------------------
	// Failure handling and compares
	//------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_data(input string name, input soc_bus_pkg::data_t exp,
		input soc_bus_pkg::data_t act);
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s: expected %08h, actual %08h", name, exp, act));
	endtask

	task automatic check_gpio_out(input string name, input soc_csr_pkg::gpio_out_t exp,
		input soc_csr_pkg::gpio_out_t act);
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s: expected %04h, actual %04h", name, exp, act));
	endtask

	task automatic check_irq(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("MISMATCH %s: expected %0b, actual %0b", name, exp, act));
	endtask

	// Run limit
	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES)
			abort_run($sformatf("Timeout after %0d clock cycles, run did not complete",
				cycle_cnt));
	end

	//------------------------------------------------------------
	// Stimulus helpers
	//------------------------------------------------------------
	// LCG, high bits folded down since low bits repeat quickly
	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state ^ (rand_state >> 16);
	endfunction

	// Random upper bits alias onto the same word
	function automatic soc_bus_pkg::adr_t bram_addr(input soc_bus_pkg::bram_idx_t idx,
		input logic [31:0] r);
		return {soc_bus_pkg::REGION_BRAM, r[16:0], idx, 2'b00};
	endfunction

	function automatic soc_bus_pkg::adr_t csr_addr(input soc_csr_pkg::csr_bank_t bank,
		input soc_csr_pkg::csr_reg_t regn);
		return {soc_bus_pkg::REGION_CSR, 13'd0, bank, regn, 2'b00};
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
		#1;
	endtask

	// One classic access, then one idle cycle
	task automatic bus_access(input soc_bus_pkg::adr_t adr, input logic we,
		input soc_bus_pkg::sel_t sel, input soc_bus_pkg::data_t wdat,
		output soc_bus_pkg::data_t rdat);
		int waited;
		wb_adr_i = adr;
		wb_we_i  = we;
		wb_sel_i = sel;
		wb_dat_i = wdat;
		wb_stb_i = 1'b1;
		waited   = 0;
		@(posedge sys_clk);
		#1;
		while (!wb_ack_o) begin
			if (waited >= ACK_LIMIT)
				abort_run($sformatf("No acknowledge for address %08h within %0d cycles",
					adr, ACK_LIMIT));
			else begin
				waited++;
				@(posedge sys_clk);
				#1;
			end
		end
		rdat     = wb_dat_o;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wait_cycles(1);
		// Ack is a single-cycle pulse
		if (wb_ack_o !== 1'b0)
			abort_run($sformatf("wb_ack_o stayed high for more than one cycle at address %08h",
				adr));
	endtask

	task automatic csr_read(input soc_csr_pkg::csr_bank_t bank,
		input soc_csr_pkg::csr_reg_t regn, output soc_bus_pkg::data_t rdat);
		bus_access(csr_addr(bank, regn), 1'b0, 4'hf, '0, rdat);
	endtask

	task automatic csr_write(input soc_csr_pkg::csr_bank_t bank,
		input soc_csr_pkg::csr_reg_t regn, input soc_bus_pkg::data_t wdat);
		soc_bus_pkg::data_t unused_rdat;
		bus_access(csr_addr(bank, regn), 1'b1, 4'hf, wdat, unused_rdat);
	endtask

	//------------------------------------------------------------
	// Test phases
	//------------------------------------------------------------
	task automatic exercise_bram(input int n_ops);
		soc_bus_pkg::bram_idx_t idx;
		soc_bus_pkg::sel_t      sel;
		soc_bus_pkg::data_t     wdat;
		soc_bus_pkg::data_t     rdat;
		for (int k = 0; k < n_ops; k++) begin
			if (written_q.size() == 0 || next_rand() % 2 == 0) begin
				idx  = soc_bus_pkg::bram_idx_t'(next_rand());
				// First write fills the whole word, later ones random lanes
				sel  = bram_written[idx] ? soc_bus_pkg::sel_t'(next_rand()) : 4'hf;
				wdat = next_rand();
				bus_access(bram_addr(idx, next_rand()), 1'b1, sel, wdat, rdat);
				if (bram_written[idx])
					check_data("bram write old word", bram_model[idx], rdat);
				else begin
					bram_written[idx] = 1'b1;
					written_q.push_back(idx);
				end
				for (int i = 0; i < soc_bus_pkg::SEL_W; i++) begin
					if (sel[i])
						bram_model[idx][8*i +: 8] = wdat[8*i +: 8];
				end
			end else begin
				idx = written_q[next_rand() % written_q.size()];
				bus_access(bram_addr(idx, next_rand()), 1'b0, 4'hf, '0, rdat);
				check_data("bram read", bram_model[idx], rdat);
			end
		end
	endtask

	task automatic probe_default_regions(input int n_ops);
		soc_bus_pkg::region_t   region;
		soc_bus_pkg::bram_idx_t idx;
		logic [31:0]            r;
		logic                   we;
		soc_bus_pkg::data_t     rdat;
		for (int k = 0; k < n_ops; k++) begin
			region = soc_bus_pkg::region_t'(next_rand());
			// Step off the two populated regions
			if (region == soc_bus_pkg::REGION_BRAM || region == soc_bus_pkg::REGION_CSR)
				region = region + 3'd1;
			r  = next_rand();
			we = (next_rand() % 2 == 0);
			bus_access({region, r[28:0]}, we, 4'hf, next_rand(), rdat);
			if (!we)
				check_data("default region read", soc_bus_pkg::DEFAULT_DATA, rdat);
		end
		// Stray writes left the other targets alone
		check_gpio_out("gpio_out after default writes", gpio_out_model, gpio_out_o);
		for (int k = 0; k < 8; k++) begin
			idx = written_q[next_rand() % written_q.size()];
			bus_access(bram_addr(idx, next_rand()), 1'b0, 4'hf, '0, rdat);
			check_data("bram after default writes", bram_model[idx], rdat);
		end
	endtask

	task automatic verify_csr_map(input int n_ops);
		soc_bus_pkg::data_t     wdat;
		soc_bus_pkg::data_t     rdat;
		soc_csr_pkg::csr_bank_t bank;
		soc_csr_pkg::csr_reg_t  regn;
		csr_read(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_SYS_ID, rdat);
		check_data("system id", soc_csr_pkg::SYSTEM_ID, rdat);
		for (int k = 0; k < n_ops; k++) begin
			wdat = next_rand();
			csr_write(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_GPIO_OUT, wdat);
			gpio_out_model = wdat[soc_csr_pkg::GPIO_OUT_W-1:0];
			check_gpio_out("gpio_out pins", gpio_out_model, gpio_out_o);
			csr_read(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_GPIO_OUT, rdat);
			check_data("gpio_out readback", soc_bus_pkg::data_t'(gpio_out_model), rdat);
		end
		// Other banks neither store nor answer
		for (int k = 0; k < n_ops; k++) begin
			bank = soc_csr_pkg::csr_bank_t'(next_rand());
			if (bank == soc_csr_pkg::SYSCTL_BANK)
				bank = 4'd0;
			regn = soc_csr_pkg::csr_reg_t'(next_rand() % 5);
			csr_write(bank, soc_csr_pkg::REG_GPIO_OUT, next_rand());
			check_gpio_out("gpio_out after other bank write", gpio_out_model, gpio_out_o);
			csr_read(bank, regn, rdat);
			check_data("other bank read", '0, rdat);
		end
		// Holes above the last register
		for (int k = 0; k < n_ops; k++) begin
			regn = soc_csr_pkg::csr_reg_t'(next_rand());
			if (regn <= soc_csr_pkg::REG_SYS_ID)
				regn = regn + 10'd5;
			csr_read(soc_csr_pkg::SYSCTL_BANK, regn, rdat);
			check_data("unmapped register read", '0, rdat);
		end
	endtask

	task automatic run_gpio_irq(input int n_rounds);
		soc_csr_pkg::gpio_in_t new_in;
		soc_bus_pkg::data_t    wdat;
		soc_bus_pkg::data_t    rdat;
		wdat       = next_rand();
		mask_model = wdat[soc_csr_pkg::GPIO_IN_W-1:0];
		csr_write(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_MASK, wdat);
		csr_read(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_MASK, rdat);
		check_data("irq mask readback", soc_bus_pkg::data_t'(mask_model), rdat);
		for (int k = 0; k < n_rounds; k++) begin
			new_in        = soc_csr_pkg::gpio_in_t'(next_rand());
			pend_model    = pend_model | (gpio_in_model ^ new_in);
			gpio_in_model = new_in;
			gpio_in_i     = new_in;
			// Synchronizer, edge detect and irq register
			wait_cycles(5);
			check_irq("irq after input change", |(pend_model & mask_model), irq_o);
			csr_read(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_GPIO_IN, rdat);
			check_data("gpio_in read", soc_bus_pkg::data_t'(gpio_in_model), rdat);
			csr_read(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_PEND, rdat);
			check_data("pending bits", soc_bus_pkg::data_t'(pend_model), rdat);
			wdat = next_rand();
			case (next_rand() % 4)
				0: begin
					mask_model = wdat[soc_csr_pkg::GPIO_IN_W-1:0];
					csr_write(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_MASK, wdat);
					check_irq("irq after mask write", |(pend_model & mask_model), irq_o);
				end
				1: begin
					pend_model = pend_model & ~wdat[soc_csr_pkg::GPIO_IN_W-1:0];
					csr_write(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_PEND, wdat);
					check_irq("irq after partial clear", |(pend_model & mask_model), irq_o);
				end
				default: begin
				end
			endcase
		end
		// Directed raise and clear with every source enabled
		mask_model = '1;
		csr_write(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_MASK, 32'h1fff);
		// Start with nothing pending so bit 0 alone raises the line
		pend_model = '0;
		csr_write(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_PEND, 32'h1fff);
		check_irq("irq before bit 0 change", 1'b0, irq_o);
		new_in        = gpio_in_model ^ 13'h0001;
		pend_model    = pend_model | 13'h0001;
		gpio_in_model = new_in;
		gpio_in_i     = new_in;
		wait_cycles(5);
		check_irq("irq raised by bit 0", 1'b1, irq_o);
		csr_read(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_PEND, rdat);
		check_data("pending after bit 0 change", soc_bus_pkg::data_t'(pend_model), rdat);
		pend_model = '0;
		csr_write(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_PEND, 32'h1fff);
		check_irq("irq after clearing all", 1'b0, irq_o);
		csr_read(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_PEND, rdat);
		check_data("pending after clearing all", '0, rdat);
	endtask

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial begin
		soc_bus_pkg::data_t rdat;
		wb_adr_i       = '0;
		wb_dat_i       = '0;
		wb_sel_i       = '0;
		wb_we_i        = 1'b0;
		wb_stb_i       = 1'b0;
		gpio_in_i      = '0;
		gpio_in_model  = '0;
		gpio_out_model = '0;
		mask_model     = '0;
		pend_model     = '0;
		@(posedge arst_n);
		wait_cycles(1);

		// Reset state
		if (wb_ack_o !== 1'b0)
			abort_run("wb_ack_o is not low after reset");
		check_gpio_out("gpio_out after reset", '0, gpio_out_o);
		check_irq("irq after reset", 1'b0, irq_o);
		csr_read(soc_csr_pkg::SYSCTL_BANK, soc_csr_pkg::REG_IRQ_MASK, rdat);
		check_data("irq mask after reset", '0, rdat);

		exercise_bram(150);
		probe_default_regions(24);
		verify_csr_map(12);
		run_gpio_irq(25);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
